// ==== tb.f ====
src/rec_pkg.sv
src/i2s_recorder.sv
src/sample_buffer.sv
src/mem_writer.sv
src/aud_rec_top.sv
test/tb_aud_rec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the recorder testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_aud_rec -f tb.f -o tb_aud_rec \
    && ./obj_dir/tb_aud_rec 2>&1 | tee /dev/stderr | grep -x "Test passed" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== test/tb_aud_rec.sv ====
`timescale 1ns/1ns

module tb_aud_rec;
    import rec_pkg::*;

    localparam int FRAME_CYCLES   = 2 * SLOT_BITS;
    localparam int TEST_FRAMES    = 117;
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES * 2;

    logic                 i_clk      = 1'b0;
    logic                 i_rst_n    = 1'b1;
    logic                 i_start    = 1'b0;
    logic                 i_pause    = 1'b0;
    logic                 i_stop     = 1'b0;
    logic                 i_lrc      = 1'b0;
    logic                 i_data     = 1'b0;
    logic                 i_mem_busy = 1'b0;
    logic                 o_mem_we;
    logic [ADDR_BITS-1:0] o_mem_addr;
    sample_t              o_mem_data;
    logic                 o_recording;
    logic                 o_overrun;
    logic                 o_done;

    logic [31:0] lfsr        = 32'd98660;
    int          pos         = 0;        // Bit clock within the 64-cycle frame.
    sample_t     cur_sample  = '0;
    sample_t     sent[$];                // Left samples sent while capturing.
    logic        capture_on  = 1'b0;
    logic        lossy       = 1'b0;     // Drops allowed after an overrun.
    int          busy_mode   = 0;        // 0 idle, 1 random, 2 held.
    int          next_addr   = 0;
    int          rec_base    = 0;
    int          lost        = 0;
    int          done_count  = 0;
    int          cycles      = 0;
    int          done_before;
    int          addr_before;

    aud_rec_top dut_i (.*);

    initial begin
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    // Word at an address, given how many sent samples were lost before it.
    function automatic sample_t expected_word(input int addr, input int skipped);
        return sent[rec_base + skipped + addr];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("MISMATCH at %0t ns: %s is %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic wait_pos(input int p);
        do @(posedge i_clk); while (pos != p);
    endtask

    task automatic wait_frames(input int n);
        repeat (n * FRAME_CYCLES) @(posedge i_clk);
    endtask

    // Controls go in during the right half, well clear of any left frame.
    task automatic press_control(input logic start, input logic pause, input logic stop);
        wait_pos(48);
        i_start <= start;
        i_pause <= pause;
        i_stop  <= stop;
        @(posedge i_clk);
        i_start <= 1'b0;
        i_pause <= 1'b0;
        i_stop  <= 1'b0;
    endtask

    // ########################################################################
    // Codec and memory busy driver
    // ########################################################################
    always @(posedge i_clk) begin
        if (pos == 0) begin
            for (int i = 0; i < SAMPLE_BITS; i++) begin
                cur_sample = {cur_sample[SAMPLE_BITS-2:0], rand_bit()};
            end
            if (capture_on) begin
                sent.push_back(cur_sample);
            end
        end
        i_lrc <= (pos >= SLOT_BITS);  // Low is the left channel.
        if (pos >= 1 && pos <= SAMPLE_BITS) begin
            i_data <= cur_sample[SAMPLE_BITS - pos];
        end else begin
            i_data <= rand_bit();  // Skip bit and unused slot bits.
        end
        case (busy_mode)
            1:       i_mem_busy <= rand_bit() & rand_bit();
            2:       i_mem_busy <= 1'b1;
            default: i_mem_busy <= 1'b0;
        endcase
        pos <= (pos + 1) % FRAME_CYCLES;
    end

    // ########################################################################
    // Memory model and compare
    // ########################################################################
    always @(posedge i_clk) begin
        int idx;
        if (!i_rst_n && i_start) begin
            next_addr <= 0;
            rec_base  <= sent.size();
            lost      <= 0;
        end else if (!i_rst_n && o_mem_we && !i_mem_busy) begin
            idx = rec_base + lost + next_addr;
            while (lossy && idx < sent.size() && sent[idx] != o_mem_data) begin
                idx++;
            end
            if (idx >= sent.size()) begin
                fail_now("Memory write with no matching sample left in the sent list");
            end
            if (next_addr >= MEM_WORDS) begin
                fail_now("Memory write past the last memory word");
            end
            check_eq("o_mem_addr", o_mem_addr, next_addr);
            check_eq("o_mem_data", o_mem_data,
                     expected_word(next_addr, idx - rec_base - next_addr));
            lost      <= idx - rec_base - next_addr;
            next_addr <= next_addr + 1;
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst_n && o_done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge i_clk) begin
        rec_state_t st;
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            st = dut_i.recorder_i.state_r;
            fail_now($sformatf("Timeout after %0d cycles with the recorder in %s",
                               cycles, st.name()));
        end
    end

    // ########################################################################
    // Scenarios
    // ########################################################################
    initial begin
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b0;

        press_control(1'b1, 1'b0, 1'b0);
        capture_on <= 1'b1;
        wait_frames(6);
        check_eq("write count", next_addr, 6);

        press_control(1'b0, 1'b1, 1'b0);  // Pause.
        capture_on <= 1'b0;
        wait_frames(3);
        press_control(1'b0, 1'b1, 1'b0);  // Resume.
        capture_on <= 1'b1;
        wait_frames(4);
        check_eq("write count", next_addr, 11);

        busy_mode <= 1;
        wait_frames(12);
        busy_mode <= 0;
        check_eq("write count", next_addr, 23);
        check_eq("o_overrun", o_overrun, 1'b0);

        lossy     <= 1'b1;
        busy_mode <= 2;  // Longer than the buffer can cover.
        wait_frames(8);
        busy_mode <= 0;
        wait_frames(6);
        check_eq("o_overrun", o_overrun, 1'b1);

        done_before = done_count;
        press_control(1'b0, 1'b0, 1'b1);
        capture_on <= 1'b0;
        addr_before = next_addr;
        wait_frames(4);
        check_eq("o_recording", o_recording, 1'b0);
        check_eq("o_done pulses", done_count, done_before + 1);
        check_eq("write count", next_addr, addr_before);

        lossy <= 1'b0;
        press_control(1'b1, 1'b0, 1'b0);
        capture_on <= 1'b1;
        do @(posedge i_clk); while (!o_done);
        wait_frames(2);
        check_eq("write count", next_addr, MEM_WORDS);
        check_eq("o_done pulses", done_count, done_before + 2);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== src/aud_rec_top.sv ====
`timescale 1ns/1ns

module aud_rec_top (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,
    input  logic                          i_pause,
    input  logic                          i_stop,
    input  logic                          i_lrc,
    input  logic                          i_data,
    input  logic                          i_mem_busy,
    output logic                          o_mem_we,
    output logic [rec_pkg::ADDR_BITS-1:0] o_mem_addr,
    output rec_pkg::sample_t              o_mem_data,
    output logic                          o_recording,
    output logic                          o_overrun,
    output logic                          o_done
);
    import rec_pkg::*;

    logic    s_valid;
    sample_t s_data;
    logic    credit_ret;
    logic    b_valid;
    sample_t b_data;
    logic    b_pop;
    logic    mem_full;

    i2s_recorder recorder_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_lrc        (i_lrc),
        .i_data       (i_data),
        .i_mem_full   (mem_full),
        .i_credit_ret (credit_ret),
        .o_valid      (s_valid),
        .o_data       (s_data),
        .o_recording  (o_recording),
        .o_overrun    (o_overrun),
        .o_done       (o_done)
    );

    sample_buffer #(
        .DEPTH (BUF_DEPTH)
    ) buffer_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (s_valid),
        .i_push_data (s_data),
        .i_pop       (b_pop),
        .o_valid     (b_valid),
        .o_head      (b_data),
        .o_credit    (credit_ret)
    );

    mem_writer writer_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (b_valid),
        .i_head     (b_data),
        .i_mem_busy (i_mem_busy),
        .i_start    (i_start),
        .o_pop      (b_pop),
        .o_mem_we   (o_mem_we),
        .o_mem_addr (o_mem_addr),
        .o_mem_data (o_mem_data),
        .o_mem_full (mem_full)
    );

endmodule

// ==== src/mem_writer.sv ====
`timescale 1ns/1ns

module mem_writer (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_valid,
    input  rec_pkg::sample_t              i_head,
    input  logic                          i_mem_busy,
    input  logic                          i_start,
    output logic                          o_pop,
    output logic                          o_mem_we,
    output logic [rec_pkg::ADDR_BITS-1:0] o_mem_addr,
    output rec_pkg::sample_t              o_mem_data,
    output logic                          o_mem_full
);
    import rec_pkg::*;

    logic accept;

    assign o_pop  = i_valid && !o_mem_we && !o_mem_full;
    assign accept = o_mem_we && !i_mem_busy;  // Write lands this cycle.

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_mem_we   <= 1'b0;
            o_mem_addr <= '0;
            o_mem_full <= 1'b0;
        end else begin
            if (accept) begin
                o_mem_we <= 1'b0;
            end else if (o_pop) begin
                o_mem_we <= 1'b1;
            end

            // New recording always starts at word 0.
            if (i_start) begin
                o_mem_addr <= '0;
                o_mem_full <= 1'b0;
            end else if (accept) begin
                o_mem_addr <= o_mem_addr + 1'b1;
                if (o_mem_addr == ADDR_BITS'(MEM_WORDS - 1)) begin
                    o_mem_full <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_mem_data <= i_head;
        end
    end

    // Memory sees a steady request until it takes it.
    a_hold_while_busy: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_mem_we && i_mem_busy && !i_start) |=>
            (o_mem_we && $stable(o_mem_addr) && $stable(o_mem_data)));

endmodule

// ==== src/sample_buffer.sv ====
`timescale 1ns/1ns

module sample_buffer #(
    parameter int DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  rec_pkg::sample_t i_push_data,
    input  logic             i_pop,
    output logic             o_valid,
    output rec_pkg::sample_t o_head,
    output logic             o_credit
);
    import rec_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    sample_t             mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Wraps for any depth, not just powers of two.
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_valid = (count != '0);
    assign o_head  = mem[rd_ptr];

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            o_credit <= i_pop;  // One credit back per pop.
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (i_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // Full push means the producer ignored its credit count.
    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_push |-> count != CNT_BITS'(DEPTH));

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_pop |-> o_valid);

endmodule

// ==== src/i2s_recorder.sv ====
`timescale 1ns/1ns

module i2s_recorder (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_pause,
    input  logic             i_stop,
    input  logic             i_lrc,
    input  logic             i_data,
    input  logic             i_mem_full,
    input  logic             i_credit_ret,
    output logic             o_valid,
    output rec_pkg::sample_t o_data,
    output logic             o_recording,
    output logic             o_overrun,
    output logic             o_done
);
    import rec_pkg::*;

    rec_state_t                   state_r, state_w;
    logic [$clog2(SLOT_BITS)-1:0] bit_cnt_r;
    logic [SAMPLE_BITS-1:0]       shift_r;
    logic [CREDIT_BITS-1:0]       credit_r;
    logic                         active;
    logic                         shifting;
    logic                         frame_done;
    logic                         send;

    assign o_recording = state_r inside {S_WAIT_HIGH, S_WAIT_LOW, S_SKIP, S_CAPTURE};
    assign active      = o_recording || (state_r == S_PAUSE);
    assign shifting    = state_r inside {S_SKIP, S_CAPTURE};
    assign o_done      = (state_r == S_FINISH);
    assign send        = frame_done && (credit_r != '0);

    // #########################################################################
    // Frame state machine
    // #########################################################################
    always_comb begin
        state_w    = state_r;
        frame_done = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w = S_WAIT_HIGH;
                end
            end
            S_WAIT_HIGH: begin
                if (i_lrc) begin
                    state_w = S_WAIT_LOW;
                end
            end
            S_WAIT_LOW: begin
                if (!i_lrc) begin
                    state_w = S_SKIP;  // Skip bit is on this edge.
                end
            end
            S_SKIP: begin
                state_w = S_CAPTURE;   // MSB taken here.
            end
            S_CAPTURE: begin
                if (bit_cnt_r == SAMPLE_BITS - 1) begin
                    state_w    = S_WAIT_HIGH;
                    frame_done = 1'b1;
                end
            end
            S_PAUSE: begin
                if (i_pause) begin
                    state_w = S_WAIT_HIGH;  // Resume on the next left frame.
                end
            end
            S_FINISH: begin
                state_w = S_IDLE;
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase

        // A pause drops whatever frame is in flight.
        if (o_recording && i_pause) begin
            state_w    = S_PAUSE;
            frame_done = 1'b0;
        end
        if (active && (i_stop || i_mem_full)) begin
            state_w    = S_FINISH;
            frame_done = 1'b0;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r   <= S_IDLE;
            bit_cnt_r <= '0;
            credit_r  <= CREDIT_BITS'(BUF_DEPTH);
            o_valid   <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            state_r   <= state_w;
            bit_cnt_r <= shifting ? bit_cnt_r + 1'b1 : '0;
            o_valid   <= send;

            case ({send, i_credit_ret})
                2'b10:   credit_r <= credit_r - 1'b1;
                2'b01:   credit_r <= credit_r + 1'b1;
                default: credit_r <= credit_r;
            endcase

            if (state_r == S_IDLE && i_start) begin
                o_overrun <= 1'b0;
            end else if (frame_done && !send) begin
                o_overrun <= 1'b1;  // No free slot, sample lost.
            end
        end
    end

    // #########################################################################
    // Deserialiser
    // #########################################################################
    always_ff @(posedge i_clk) begin
        if (shifting) begin
            shift_r <= {shift_r[SAMPLE_BITS-2:0], i_data};
        end
        if (send) begin
            o_data <= {shift_r[SAMPLE_BITS-2:0], i_data};
        end
    end

    // #########################################################################
    // Checks
    // #########################################################################
    // Holds only if the buffer returns exactly one credit per pop.
    a_credit_bound: assert property (@(posedge i_clk) disable iff (i_rst_n)
        credit_r <= CREDIT_BITS'(BUF_DEPTH));

endmodule

// ==== src/rec_pkg.sv ====
package rec_pkg;

    // Audio format.
    localparam int SAMPLE_BITS = 16;   // Bits captured per left frame.
    localparam int SLOT_BITS   = 32;   // Bit clocks per channel half.

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // Sample memory.
    localparam int ADDR_BITS = 20;
    localparam int MEM_WORDS = 64;     // Recording ends here.

    // Buffer slots, one credit each.
    localparam int BUF_DEPTH   = 4;
    localparam int CREDIT_BITS = $clog2(BUF_DEPTH + 1);

    // Recorder states.
    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_HIGH,
        S_WAIT_LOW,
        S_SKIP,
        S_CAPTURE,
        S_PAUSE,
        S_FINISH
    } rec_state_t;

endpackage
